// ==== compile.f ====
+incdir+.
corePkg.sv
decodeCtrlIf.sv
fetchUnit.sv
instrDecoder.sv
registerFile.sv
executeUnit.sv
storeAlign.sv
computeCore.sv
computeCoreTb.sv

// ==== computeCore.sv ====
// Single-cycle RV32 subset core; instruction and data memories must answer in the same cycle
module computeCore (
    input  logic             clk,
    input  logic             reset,
    input  corePkg::instr_t  instr,
    input  corePkg::word_t   memReadData,
    output corePkg::word_t   pc,
    output logic             memEn,
    output logic             memWriteEn,
    output corePkg::byteEn_t memByteEn,
    output corePkg::word_t   memAdr,
    output corePkg::word_t   memWriteData
);

    decodeCtrlIf ctrl ();

    corePkg::word_t   pcPlus4;
    corePkg::regAdr_t rs1Adr;
    corePkg::regAdr_t rs2Adr;
    corePkg::regAdr_t rdAdr;
    corePkg::word_t   rs1Data;
    corePkg::word_t   rs2Data;
    corePkg::word_t   rdData;
    corePkg::word_t   aluResult;
    logic             branchTaken;

    fetchUnit fetch (
        .clk, .reset,
        .branchTaken,
        .imm (ctrl.imm),
        .pc,
        .pcPlus4
    );

    instrDecoder decoder (
        .reset, .instr,
        .rs1Adr, .rs2Adr, .rdAdr,
        .ctrl (ctrl.source)
    );

    // Write-back lands at the edge that retires the instruction
    registerFile regFile (
        .clk, .reset,
        .writeEn (ctrl.regWrite),
        .rdAdr, .rdData,
        .rs1Adr, .rs2Adr,
        .rs1Data, .rs2Data
    );

    executeUnit execute (
        .rs1Data, .rs2Data, .pcPlus4, .memReadData,
        .ctrl (ctrl.sink),
        .aluResult, .rdData, .branchTaken
    );

    storeAlign store (
        .aluResult, .rs2Data,
        .ctrl (ctrl.sink),
        .memAdr, .memByteEn, .memWriteData
    );

    assign memEn      = ctrl.memEn;
    assign memWriteEn = ctrl.memWriteEn;

endmodule

// ==== computeCoreTb.sv ====
// Directed tests; memories hold 64 words, programs start at address 0 and data stays below 256
`include "coreDefs_params.svh"

module computeCoreTb;

    localparam int          CYCLE_LIMIT = 400;
    localparam logic [6:0]  OP_IMM      = 7'b0010011;
    localparam logic [6:0]  OP_LOAD     = 7'b0000011;
    localparam logic [31:0] NOP         = 32'h0000_0013;
    // funct3 of ADD, SUB, AND, OR, XOR, SLT from the low end up
    localparam logic [17:0] ALU_F3      = {3'b010, 3'b100, 3'b110, 3'b111, 3'b000, 3'b000};

    logic             clk;
    logic             reset;
    corePkg::instr_t  instr;
    corePkg::word_t   memReadData;
    corePkg::word_t   pc;
    logic             memEn;
    logic             memWriteEn;
    corePkg::byteEn_t memByteEn;
    corePkg::word_t   memAdr;
    corePkg::word_t   memWriteData;

    logic [31:0] imem [64];
    logic [31:0] dmem [64];
    // Expected memory access for each instruction slot
    logic        expStore [64];
    logic        expLoad [64];
    logic [31:0] expAdr [64];
    logic [3:0]  expBe [64];
    logic [31:0] expData [64];
    logic [31:0] pathQ [$];
    int          progLen;
    int          cycles;

    computeCore u_dut (.*);

    always #4 clk = ~clk;

    assign instr       = imem[pc[7:2]];
    assign memReadData = dmem[memAdr[7:2]];

    always @(posedge clk) begin
        if (memWriteEn) begin
            for (int l = 0; l < 4; l++) begin
                if (memByteEn[l]) begin
                    dmem[memAdr[7:2]][8*l +: 8] <= memWriteData[8*l +: 8];
                end
            end
        end
    end

    // Six short programs with their resets need well under 200 cycles
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run went past %0d cycles", CYCLE_LIMIT);
            $display("Test failed");
            $fatal(1);
        end
    end

    task automatic checkWord(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
        assert (actual === expected) else begin
            $display("mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    // Instruction encoders
    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encS(input logic [2:0] f3, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] encB(input logic [2:0] f3, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] encU(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // Reference ALU from the ISA rules
    function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic sub,
                                           input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return sub ? a - b : a + b;
            3'b111:  return a & b;
            3'b110:  return a | b;
            3'b100:  return a ^ b;
            default: return {31'b0, $signed(a) < $signed(b)};
        endcase
    endfunction

    function automatic logic [31:0] laneMask(input logic [3:0] be);
        logic [31:0] mask;
        for (int l = 0; l < 4; l++) begin
            mask[8*l +: 8] = {8{be[l]}};
        end
        return mask;
    endfunction

    function automatic void emit(input logic [31:0] word);
        imem[progLen] = word;
        progLen++;
    endfunction

    function automatic void emitStore(input logic [31:0] word, input logic [31:0] adr,
                                      input logic [3:0] be, input logic [31:0] data);
        expStore[progLen] = 1'b1;
        expAdr[progLen]   = adr;
        expBe[progLen]    = be;
        expData[progLen]  = data;
        emit(word);
    endfunction

    function automatic void emitLoad(input logic [31:0] word, input logic [31:0] adr);
        expLoad[progLen] = 1'b1;
        expAdr[progLen]  = adr;
        emit(word);
    endfunction

    // LUI then ADDI, upper part rounded for the sign of the low 12 bits
    function automatic void loadConst(input logic [4:0] rd, input logic [31:0] v);
        logic [31:0] upper;
        upper = (v + 32'h800) >> 12;
        emit(encU(upper[19:0], rd));
        emit(encI(v[11:0], rd, 3'b000, rd, OP_IMM));
    endfunction

    // Store to a slot no test expects, so reaching it is an error
    function automatic logic [31:0] strayStore();
        return encS(3'b010, 5'd1, 5'd0, 12'h0FC);
    endfunction

    task automatic startReset;
        @(posedge clk);
        reset <= 1'b1;
        @(negedge clk);
        progLen = 0;
        for (int i = 0; i < 64; i++) begin
            imem[i]     = NOP;
            expStore[i] = 1'b0;
            expLoad[i]  = 1'b0;
        end
    endtask

    // Reset spans three edges and the outputs stay quiet throughout
    task automatic endReset;
        repeat (2) begin
            @(posedge clk);
            @(negedge clk);
            checkWord("pc", pc, `CORE_ENTRY_ADR);
            checkWord("memEn", memEn, 32'd0);
            checkWord("memWriteEn", memWriteEn, 32'd0);
            checkWord("memByteEn", memByteEn, 32'd0);
        end
        @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
    endtask

    task automatic runPath;
        logic [31:0] p;
        int          slot;
        while (pathQ.size() > 0) begin
            p = pathQ.pop_front();
            slot = p[7:2];
            checkWord("pc", pc, p);
            checkWord("memEn", memEn, expStore[slot] | expLoad[slot]);
            checkWord("memWriteEn", memWriteEn, expStore[slot]);
            checkWord("memByteEn", memByteEn, expStore[slot] ? expBe[slot] : 4'h0);
            if (expStore[slot] || expLoad[slot]) begin
                checkWord("memAdr", memAdr, expAdr[slot]);
            end
            if (expStore[slot]) begin
                checkWord("memWriteData", memWriteData & laneMask(expBe[slot]), expData[slot]);
            end
            @(negedge clk);
        end
    endtask

    task automatic runStraight;
        for (int i = 0; i < progLen; i++) begin
            pathQ.push_back(32'(4 * i));
        end
        runPath();
    endtask

    // Store first so an ungated write during reset would show
    task automatic testReset;
        startReset();
        emitStore(encS(3'b010, 5'd0, 5'd0, 12'd0), 32'h0, 4'hF, 32'h0);
        for (int k = 1; k < 5; k++) begin
            emit(encI(12'(k), 5'd0, 3'b000, 5'(k), OP_IMM));
        end
        endReset();
        runStraight();
    endtask

    task automatic testAlu;
        logic [31:0] a;
        logic [31:0] b;
        logic [11:0] imm;
        int          slot;
        a = $urandom();
        b = $urandom();
        startReset();
        loadConst(5'd1, a);
        loadConst(5'd2, b);
        slot = 0;
        for (int k = 0; k < 6; k++) begin
            emit(encR(k == 1 ? 7'h20 : 7'h00, 5'd2, 5'd1, ALU_F3[3*k +: 3], 5'd3));
            emitStore(encS(3'b010, 5'd3, 5'd0, 12'(4 * slot)), 32'(4 * slot), 4'hF,
                      aluRef(ALU_F3[3*k +: 3], k == 1, a, b));
            slot++;
        end
        // Immediate forms, SUB has none
        for (int k = 0; k < 6; k++) begin
            if (k != 1) begin
                imm = 12'($urandom());
                emit(encI(imm, 5'd1, ALU_F3[3*k +: 3], 5'd3, OP_IMM));
                emitStore(encS(3'b010, 5'd3, 5'd0, 12'(4 * slot)), 32'(4 * slot), 4'hF,
                          aluRef(ALU_F3[3*k +: 3], 1'b0, a, {{20{imm[11]}}, imm}));
                slot++;
            end
        end
        endReset();
        runStraight();
    endtask

    task automatic testStoreWidths;
        logic [31:0] v;
        v = $urandom();
        startReset();
        loadConst(5'd5, v);
        emit(encI(12'h040, 5'd0, 3'b000, 5'd6, OP_IMM));
        for (int off = 0; off < 4; off++) begin
            emitStore(encS(3'b000, 5'd5, 5'd6, 12'(off)), 32'h40, 4'b0001 << off,
                      {24'b0, v[7:0]} << (8 * off));
        end
        for (int off = 0; off < 4; off += 2) begin
            emitStore(encS(3'b001, 5'd5, 5'd6, 12'(off)), 32'h40, 4'b0011 << off,
                      {16'b0, v[15:0]} << (8 * off));
        end
        endReset();
        runStraight();
    endtask

    task automatic testLoad;
        logic [31:0] v;
        v = $urandom();
        startReset();
        dmem[20] = v;
        emitLoad(encI(12'd80, 5'd0, 3'b010, 5'd7, OP_LOAD), 32'd80);
        emitStore(encS(3'b010, 5'd7, 5'd0, 12'd84), 32'd84, 4'hF, v);
        endReset();
        runStraight();
    endtask

    task automatic testBranches;
        startReset();
        emit(encI(12'd5, 5'd0, 3'b000, 5'd1, OP_IMM));
        emit(encI(12'd5, 5'd0, 3'b000, 5'd2, OP_IMM));
        emit(encI(12'd7, 5'd0, 3'b000, 5'd3, OP_IMM));
        // BEQ taken at 12, BEQ not taken at 24, BNE taken at 28
        emit(encB(3'b000, 5'd2, 5'd1, 13'd12));
        emit(strayStore());
        emit(strayStore());
        emit(encB(3'b000, 5'd3, 5'd1, 13'd8));
        emit(encB(3'b001, 5'd3, 5'd1, 13'd12));
        emit(strayStore());
        emit(strayStore());
        emitStore(encS(3'b010, 5'd1, 5'd0, 12'h060), 32'h60, 4'hF, 32'd5);
        endReset();
        pathQ.push_back(32'd0);
        pathQ.push_back(32'd4);
        pathQ.push_back(32'd8);
        pathQ.push_back(32'd12);
        pathQ.push_back(32'd12 + 32'd12);
        pathQ.push_back(32'd24 + 32'd4);
        pathQ.push_back(32'd28 + 32'd12);
        runPath();
    endtask

    task automatic testJump;
        startReset();
        emit(NOP);
        emit(encJ(21'd16, 5'd1));
        emit(strayStore());
        emit(strayStore());
        emit(strayStore());
        // Link value is the JAL address plus 4
        emitStore(encS(3'b010, 5'd1, 5'd0, 12'h064), 32'h64, 4'hF, 32'd4 + 32'd4);
        endReset();
        pathQ.push_back(32'd0);
        pathQ.push_back(32'd4);
        pathQ.push_back(32'd4 + 32'd16);
        runPath();
    endtask

    initial begin
        void'($urandom(34024));
        clk    = 1'b0;
        reset  = 1'b1;
        cycles = 0;
        for (int i = 0; i < 64; i++) begin
            imem[i]     = NOP;
            dmem[i]     = 32'hD000_0000 | (i * 32'h0001_0101);
            expStore[i] = 1'b0;
            expLoad[i]  = 1'b0;
        end
        testReset();
        testAlu();
        testStoreWidths();
        testLoad();
        testBranches();
        testJump();
        $display("Test passed");
        $finish;
    end

endmodule

// ==== coreDefs_params.svh ====
// Core sizing macros; only a 32-bit word with 4 byte lanes and 32 registers is supported
`ifndef CORE_DEFS_PARAMS_SVH
`define CORE_DEFS_PARAMS_SVH

// Data and address width
`define CORE_XLEN 32

// Architectural registers including x0
`define CORE_REG_COUNT 32

// Bytes per data word
`define CORE_BYTE_LANES (`CORE_XLEN / 8)

// PC value held during reset
`define CORE_ENTRY_ADR 32'h0000_0000

`endif

// ==== corePkg.sv ====
// Shared types of the single-cycle core; enum encodings are internal and carry no ISA meaning
`include "coreDefs_params.svh"

package corePkg;

    // Data paths
    typedef logic [`CORE_XLEN-1:0] word_t;
    typedef logic [31:0] instr_t;
    typedef logic [$clog2(`CORE_REG_COUNT)-1:0] regAdr_t;
    typedef logic [`CORE_BYTE_LANES-1:0] byteEn_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } aluOp_t;

    typedef enum logic {
        SRC_B_REG,
        SRC_B_IMM
    } srcB_t;

    // Write-back source
    typedef enum logic [1:0] {
        RESULT_ALU,
        RESULT_MEMORY,
        RESULT_PASS
    } resultSrc_t;

    // LUI uses the immediate, JAL the link address
    typedef enum logic {
        PASS_IMM,
        PASS_PC4
    } passSrc_t;

    typedef enum logic [1:0] {
        STORE_BYTE,
        STORE_HALF,
        STORE_WORD
    } storeType_t;

    typedef enum logic [1:0] {
        BRANCH_NONE,
        BRANCH_EQ,
        BRANCH_NE,
        BRANCH_JUMP
    } branchType_t;

    typedef enum logic [2:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J
    } immType_t;

endpackage

// ==== decodeCtrlIf.sv ====
// Decoded control of the current instruction; plain levels, valid for one cycle only
interface decodeCtrlIf;

    corePkg::aluOp_t      aluOp;
    corePkg::srcB_t       srcB;
    corePkg::resultSrc_t  resultSrc;
    corePkg::passSrc_t    passSrc;
    corePkg::branchType_t branchType;
    logic                 regWrite;
    logic                 memEn;
    logic                 memWriteEn;
    corePkg::storeType_t  storeType;
    corePkg::word_t       imm;

    // Decoder side
    modport source (
        output aluOp, srcB, resultSrc, passSrc, branchType,
        output regWrite, memEn, memWriteEn, storeType, imm
    );

    // Execute and store side
    modport sink (
        input aluOp, srcB, resultSrc, passSrc, branchType,
        input regWrite, memEn, memWriteEn, storeType, imm
    );

endinterface

// ==== executeUnit.sv ====
// ALU, branch compare and write-back select; SLT is the only compare and it is signed
module executeUnit (
    input  corePkg::word_t rs1Data,
    input  corePkg::word_t rs2Data,
    input  corePkg::word_t pcPlus4,
    input  corePkg::word_t memReadData,
    decodeCtrlIf.sink      ctrl,
    output corePkg::word_t aluResult,
    output corePkg::word_t rdData,
    output logic           branchTaken
);

    corePkg::word_t operandB;
    corePkg::word_t passthrough;
    logic           operandsEqual;

    assign operandB = (ctrl.srcB == corePkg::SRC_B_IMM) ? ctrl.imm : rs2Data;

    always_comb begin
        case (ctrl.aluOp)
            corePkg::ALU_ADD: aluResult = rs1Data + operandB;
            corePkg::ALU_SUB: aluResult = rs1Data - operandB;
            corePkg::ALU_AND: aluResult = rs1Data & operandB;
            corePkg::ALU_OR:  aluResult = rs1Data | operandB;
            corePkg::ALU_XOR: aluResult = rs1Data ^ operandB;
            corePkg::ALU_SLT:
                aluResult = corePkg::word_t'($signed(rs1Data) < $signed(operandB));
            default:          aluResult = '0;
        endcase
    end

    // Branches always compare the two registers
    assign operandsEqual = (rs1Data == rs2Data);

    always_comb begin
        case (ctrl.branchType)
            corePkg::BRANCH_EQ:   branchTaken = operandsEqual;
            corePkg::BRANCH_NE:   branchTaken = ~operandsEqual;
            corePkg::BRANCH_JUMP: branchTaken = 1'b1;
            default:              branchTaken = 1'b0;
        endcase
    end

    assign passthrough = (ctrl.passSrc == corePkg::PASS_PC4) ? pcPlus4 : ctrl.imm;

    always_comb begin
        case (ctrl.resultSrc)
            corePkg::RESULT_MEMORY: rdData = memReadData;
            corePkg::RESULT_PASS:   rdData = passthrough;
            default:                rdData = aluResult;
        endcase
    end

endmodule

// ==== fetchUnit.sv ====
// Program counter; no stall input, so a new PC is loaded at every edge after reset
`include "coreDefs_params.svh"

module fetchUnit (
    input  logic           clk,
    input  logic           reset,
    input  logic           branchTaken,
    input  corePkg::word_t imm,
    output corePkg::word_t pc,
    output corePkg::word_t pcPlus4
);

    corePkg::word_t pcTarget;
    corePkg::word_t pcNext;

    assign pcPlus4 = pc + corePkg::word_t'(4);

    // Branch and JAL targets are both PC relative
    assign pcTarget = pc + imm;

    assign pcNext = branchTaken ? pcTarget : pcPlus4;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `CORE_ENTRY_ADR;
        end else begin
            pc <= pcNext;
        end
    end

    // PC stays word aligned since only aligned targets are produced
    pcAligned: assert property (
        @(posedge clk) disable iff (reset)
        pc[1:0] == 2'b00
    );

endmodule

// ==== instrDecoder.sv ====
// RV32 subset decoder; anything outside the supported opcodes and functs is treated as a nop
module instrDecoder (
    input  logic              reset,
    input  corePkg::instr_t   instr,
    output corePkg::regAdr_t  rs1Adr,
    output corePkg::regAdr_t  rs2Adr,
    output corePkg::regAdr_t  rdAdr,
    decodeCtrlIf.source       ctrl
);

    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

    logic [6:0]        opcode;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    corePkg::aluOp_t   functOp;
    logic              functValid;
    logic              funct7Valid;
    corePkg::immType_t immType;
    logic              regWriteRaw;
    logic              memEnRaw;
    logic              memWriteEnRaw;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rdAdr  = instr[11:7];
    assign rs1Adr = instr[19:15];
    assign rs2Adr = instr[24:20];

    // ALU op shared by register and immediate forms
    always_comb begin
        functOp    = corePkg::ALU_ADD;
        functValid = 1'b1;
        case (funct3)
            3'b000: begin
                if (opcode == OP_REG && funct7[5]) begin
                    functOp = corePkg::ALU_SUB;
                end
            end
            3'b010:  functOp = corePkg::ALU_SLT;
            3'b100:  functOp = corePkg::ALU_XOR;
            3'b110:  functOp = corePkg::ALU_OR;
            3'b111:  functOp = corePkg::ALU_AND;
            // Shifts and unsigned compares
            default: functValid = 1'b0;
        endcase
    end

    // Only SUB may set funct7 in register form
    assign funct7Valid = (funct7 == 7'h00) || (funct7 == 7'h20 && funct3 == 3'b000);

    always_comb begin
        ctrl.aluOp      = corePkg::ALU_ADD;
        ctrl.srcB       = corePkg::SRC_B_REG;
        ctrl.resultSrc  = corePkg::RESULT_ALU;
        ctrl.passSrc    = corePkg::PASS_IMM;
        ctrl.branchType = corePkg::BRANCH_NONE;
        ctrl.storeType  = corePkg::STORE_WORD;
        immType         = corePkg::IMM_I;
        regWriteRaw     = 1'b0;
        memEnRaw        = 1'b0;
        memWriteEnRaw   = 1'b0;
        case (opcode)
            OP_REG: begin
                if (functValid && funct7Valid) begin
                    ctrl.aluOp  = functOp;
                    regWriteRaw = 1'b1;
                end
            end
            OP_IMM: begin
                if (functValid) begin
                    ctrl.aluOp  = functOp;
                    ctrl.srcB   = corePkg::SRC_B_IMM;
                    regWriteRaw = 1'b1;
                end
            end
            OP_LUI: begin
                ctrl.resultSrc = corePkg::RESULT_PASS;
                immType        = corePkg::IMM_U;
                regWriteRaw    = 1'b1;
            end
            OP_LOAD: begin
                // Word loads only
                if (funct3 == 3'b010) begin
                    ctrl.srcB      = corePkg::SRC_B_IMM;
                    ctrl.resultSrc = corePkg::RESULT_MEMORY;
                    regWriteRaw    = 1'b1;
                    memEnRaw       = 1'b1;
                end
            end
            OP_STORE: begin
                ctrl.srcB = corePkg::SRC_B_IMM;
                immType   = corePkg::IMM_S;
                if (funct3 <= 3'b010) begin
                    memEnRaw      = 1'b1;
                    memWriteEnRaw = 1'b1;
                end
                case (funct3)
                    3'b000:  ctrl.storeType = corePkg::STORE_BYTE;
                    3'b001:  ctrl.storeType = corePkg::STORE_HALF;
                    default: ctrl.storeType = corePkg::STORE_WORD;
                endcase
            end
            OP_BRANCH: begin
                immType = corePkg::IMM_B;
                if (funct3 == 3'b000) begin
                    ctrl.branchType = corePkg::BRANCH_EQ;
                end else if (funct3 == 3'b001) begin
                    ctrl.branchType = corePkg::BRANCH_NE;
                end
            end
            OP_JAL: begin
                ctrl.resultSrc  = corePkg::RESULT_PASS;
                ctrl.passSrc    = corePkg::PASS_PC4;
                ctrl.branchType = corePkg::BRANCH_JUMP;
                immType         = corePkg::IMM_J;
                regWriteRaw     = 1'b1;
            end
            default: ;
        endcase
    end

    // Nothing is written while reset is held
    assign ctrl.regWrite   = regWriteRaw & ~reset;
    assign ctrl.memEn      = memEnRaw & ~reset;
    assign ctrl.memWriteEn = memWriteEnRaw & ~reset;

    // Immediate extender
    always_comb begin
        case (immType)
            corePkg::IMM_I:
                ctrl.imm = corePkg::word_t'($signed(instr[31:20]));
            corePkg::IMM_S:
                ctrl.imm = corePkg::word_t'($signed({instr[31:25], instr[11:7]}));
            corePkg::IMM_B:
                ctrl.imm = corePkg::word_t'($signed({instr[31], instr[7], instr[30:25],
                                                     instr[11:8], 1'b0}));
            corePkg::IMM_U:
                ctrl.imm = corePkg::word_t'($signed({instr[31:12], 12'b0}));
            corePkg::IMM_J:
                ctrl.imm = corePkg::word_t'($signed({instr[31], instr[19:12], instr[20],
                                                     instr[30:21], 1'b0}));
            default:
                ctrl.imm = '0;
        endcase
    end

endmodule

// ==== registerFile.sv ====
// Integer register file; reads are combinational and x0 is never written
`include "coreDefs_params.svh"

module registerFile (
    input  logic              clk,
    input  logic              reset,
    input  logic              writeEn,
    input  corePkg::regAdr_t  rdAdr,
    input  corePkg::word_t    rdData,
    input  corePkg::regAdr_t  rs1Adr,
    input  corePkg::regAdr_t  rs2Adr,
    output corePkg::word_t    rs1Data,
    output corePkg::word_t    rs2Data
);

    corePkg::word_t regs [`CORE_REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `CORE_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && rdAdr != '0) begin
            regs[rdAdr] <= rdData;
        end
    end

    // x0 stays zero from reset on because writes to it are dropped
    assign rs1Data = regs[rs1Adr];
    assign rs2Data = regs[rs2Adr];

    x0ReadsZero: assert property (
        @(posedge clk) disable iff (reset)
        (rs1Adr == '0 -> rs1Data == '0) && (rs2Adr == '0 -> rs2Data == '0)
    );

endmodule

// ==== storeAlign.sv ====
// Store lane placement; misaligned stores are not split or trapped, only flagged in simulation
`include "coreDefs_params.svh"

module storeAlign (
    input  corePkg::word_t   aluResult,
    input  corePkg::word_t   rs2Data,
    decodeCtrlIf.sink        ctrl,
    output corePkg::word_t   memAdr,
    output corePkg::byteEn_t memByteEn,
    output corePkg::word_t   memWriteData
);

    localparam int OFFSET_BITS = $clog2(`CORE_BYTE_LANES);

    logic [OFFSET_BITS-1:0] offset;

    assign offset = aluResult[OFFSET_BITS-1:0];
    assign memAdr = {aluResult[`CORE_XLEN-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};

    always_comb begin
        memByteEn = '0;
        if (ctrl.memWriteEn) begin
            case (ctrl.storeType)
                corePkg::STORE_BYTE: memByteEn = corePkg::byteEn_t'(2'b01) << offset;
                corePkg::STORE_HALF: memByteEn = corePkg::byteEn_t'(2'b11) << offset;
                default:             memByteEn = '1;
            endcase
        end
    end

    // Small stores are copied into every lane and the enables pick the live ones
    always_comb begin
        case (ctrl.storeType)
            corePkg::STORE_BYTE: memWriteData = {`CORE_BYTE_LANES{rs2Data[7:0]}};
            corePkg::STORE_HALF: memWriteData = {(`CORE_BYTE_LANES / 2){rs2Data[15:0]}};
            default:             memWriteData = rs2Data;
        endcase
    end

    // Address comes from the ALU and width from the decoder
    always_comb begin
        storeAligned: assert final (
            !ctrl.memWriteEn
            || (ctrl.storeType == corePkg::STORE_HALF && offset[0] == 1'b0)
            || (ctrl.storeType == corePkg::STORE_WORD && offset == '0)
            || ctrl.storeType == corePkg::STORE_BYTE
        );
    end

endmodule
